//--- hdl/rop_pkg.sv
`default_nettype none

package rop_pkg;

    // Register file geometry
    localparam int NUM_REGS  = 32;  // Architectural registers, r0 included
    localparam int NUM_LANES = 4;   // Byte lanes per word

    typedef logic [31:0] rop_word_t;      // Full data word
    typedef logic [7:0]  rop_byte_t;      // One byte lane
    typedef logic [4:0]  rop_reg_addr_t;  // Register index
    typedef logic [1:0]  rop_lane_t;      // Byte lane index within a word

    // Operation codes
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,  // rd = rs1 + rs2
        OP_SUB = 3'd1,  // rd = rs1 - rs2, carry is the borrow
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_LDI = 3'd5   // rd = zero-extended imm
    } rop_op_e;

    // One instruction as it arrives on the strobe
    typedef struct packed {
        rop_op_e       op;
        rop_reg_addr_t rd;
        rop_reg_addr_t rs1;
        rop_reg_addr_t rs2;
        logic          byte_mode;  // Set means byte access on reads and write
        rop_lane_t     rd_lane;    // Destination lane in byte mode
        rop_lane_t     rs1_lane;
        rop_lane_t     rs2_lane;
        rop_byte_t     imm;        // Only used by OP_LDI
    } rop_instr_t;

    // Register file read port
    typedef struct packed {
        rop_reg_addr_t addr;
        logic          byte_mode;  // Return selected lane zero-padded
        rop_lane_t     lane;
    } rop_rd_req_t;

    // Register file write port
    typedef struct packed {
        logic          wen;
        rop_reg_addr_t addr;
        logic          byte_mode;  // Low byte of wdata goes to lane only
        rop_lane_t     lane;
        rop_word_t     wdata;
    } rop_wr_req_t;

    typedef struct packed {
        logic zero;   // Result is zero at the active width
        logic carry;  // Carry out, or borrow for SUB
    } rop_flags_t;

    // Result presented with the res_valid strobe
    typedef struct packed {
        rop_reg_addr_t rd;
        rop_word_t     value;
        rop_flags_t    flags;
    } rop_result_t;

endpackage

`default_nettype wire

//--- hdl/rop_ba_regfile.sv
`default_nettype none

module rop_ba_regfile (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rop_pkg::rop_rd_req_t rd_a,     // Read port A request
    input  rop_pkg::rop_rd_req_t rd_b,     // Read port B request
    output rop_pkg::rop_word_t   a_rdata,  // Word or zero-padded byte
    output rop_pkg::rop_word_t   b_rdata,
    input  rop_pkg::rop_wr_req_t wr        // Single write port
);

    import rop_pkg::*;

    // Read view of every register, r0 hardwired
    rop_word_t gpr_rdata [NUM_REGS];

    assign gpr_rdata[0] = '0;  // r0 never holds anything

    // Pick whole word or one lane of it
    function automatic rop_word_t read_port(input rop_word_t word, input rop_rd_req_t req);
        rop_byte_t sel;
        sel = word[req.lane*8 +: 8];
        if (req.byte_mode) begin
            return rop_word_t'(sel);  // Zero-extend the lane
        end
        return word;
    endfunction

    // Both ports are purely combinational
    assign a_rdata = read_port(gpr_rdata[rd_a.addr], rd_a);
    assign b_rdata = read_port(gpr_rdata[rd_b.addr], rd_b);

    // Storage for r1..r31, four byte registers each
    for (genvar r = 1; r < NUM_REGS; r++) begin : g_reg

        logic reg_hit;  // This register is the write target

        assign reg_hit = wr.wen && (wr.addr == rop_reg_addr_t'(r));

        for (genvar b = 0; b < NUM_LANES; b++) begin : g_lane

            rop_byte_t byte_q;
            logic      lane_hit;  // Lane takes part in this write

            // Word writes hit every lane, byte writes only the chosen one
            assign lane_hit = !wr.byte_mode || (wr.lane == rop_lane_t'(b));

            assign gpr_rdata[r][b*8 +: 8] = byte_q;

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    byte_q <= '0;
                end else if (reg_hit && lane_hit) begin
                    // Byte write always sources the LSB of wdata
                    byte_q <= wr.byte_mode ? wr.wdata[7:0] : wr.wdata[b*8 +: 8];
                end
            end

        end

    end

endmodule

`default_nettype wire

//--- hdl/rop_alu.sv
`default_nettype none

module rop_alu (
    input  rop_pkg::rop_op_e   op,
    input  logic               byte_mode,  // 8-bit operation when set
    input  rop_pkg::rop_word_t opa,
    input  rop_pkg::rop_word_t opb,
    input  rop_pkg::rop_byte_t imm,
    output rop_pkg::rop_word_t value,
    output rop_pkg::rop_flags_t flags
);

    import rop_pkg::*;

    localparam int WW = $bits(rop_word_t);  // Word width
    localparam int BW = $bits(rop_byte_t);  // Byte width

    // One extra bit on top holds carry or borrow
    logic [WW:0] res_w;
    logic [BW:0] res_b;

    always_comb begin
        res_w = '0;
        res_b = '0;
        case (op)
            OP_ADD: begin
                res_w = {1'b0, opa} + {1'b0, opb};
                res_b = {1'b0, opa[BW-1:0]} + {1'b0, opb[BW-1:0]};
            end
            OP_SUB: begin
                // Wraps below zero, so the top bit is the borrow
                res_w = {1'b0, opa} - {1'b0, opb};
                res_b = {1'b0, opa[BW-1:0]} - {1'b0, opb[BW-1:0]};
            end
            OP_AND: begin
                res_w = {1'b0, opa & opb};
                res_b = {1'b0, opa[BW-1:0] & opb[BW-1:0]};
            end
            OP_OR: begin
                res_w = {1'b0, opa | opb};
                res_b = {1'b0, opa[BW-1:0] | opb[BW-1:0]};
            end
            OP_XOR: begin
                res_w = {1'b0, opa ^ opb};
                res_b = {1'b0, opa[BW-1:0] ^ opb[BW-1:0]};
            end
            OP_LDI: begin
                res_w = (WW+1)'(imm);  // Zero-extended immediate
                res_b = {1'b0, imm};
            end
            default: ;  // Unused codes give zero
        endcase
    end

    // Byte result zero-extended into the word
    assign value = byte_mode ? rop_word_t'(res_b[BW-1:0]) : res_w[WW-1:0];

    assign flags.zero  = byte_mode ? (res_b[BW-1:0] == '0) : (res_w[WW-1:0] == '0);
    assign flags.carry = byte_mode ? res_b[BW] : res_w[WW];  // Bit 8 or bit 32

endmodule

`default_nettype wire

//--- hdl/rop_ctrl.sv
`default_nettype none

module rop_ctrl (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  instr_valid,  // One instruction per high cycle
    input  rop_pkg::rop_instr_t   instr,
    output rop_pkg::rop_rd_req_t  rd_a,
    output rop_pkg::rop_rd_req_t  rd_b,
    input  rop_pkg::rop_word_t    a_rdata,
    input  rop_pkg::rop_word_t    b_rdata,
    output rop_pkg::rop_op_e      alu_op,
    output logic                  alu_byte,
    output rop_pkg::rop_word_t    alu_opa,
    output rop_pkg::rop_word_t    alu_opb,
    output rop_pkg::rop_byte_t    alu_imm,
    input  rop_pkg::rop_word_t    alu_value,
    input  rop_pkg::rop_flags_t   alu_flags,
    output rop_pkg::rop_wr_req_t  wr,
    output logic                  res_valid,   // Strobe one cycle after instr_valid
    output rop_pkg::rop_result_t  res
);

    import rop_pkg::*;

    logic       do_write;  // Instruction targets a real register
    logic       use_regs;  // Instruction reads rs1/rs2
    rop_reg_addr_t rs1_addr;
    rop_reg_addr_t rs2_addr;

    // LDI and idle cycles park both read ports on r0
    assign use_regs = instr_valid && (instr.op != OP_LDI);
    assign rs1_addr = use_regs ? instr.rs1 : '0;
    assign rs2_addr = use_regs ? instr.rs2 : '0;

    // Read requests
    assign rd_a = '{
        addr:      rs1_addr,
        byte_mode: instr.byte_mode,
        lane:      instr.rs1_lane
    };
    assign rd_b = '{
        addr:      rs2_addr,
        byte_mode: instr.byte_mode,
        lane:      instr.rs2_lane
    };

    // ALU steering, operands come straight from the read ports
    assign alu_op   = instr.op;
    assign alu_byte = instr.byte_mode;
    assign alu_opa  = a_rdata;
    assign alu_opb  = b_rdata;
    assign alu_imm  = instr.imm;

    // Writes to r0 are dropped here
    assign do_write = instr_valid && (instr.rd != '0);

    // Write-back lands on the same edge as the result register
    assign wr = '{
        wen:       do_write,
        addr:      instr.rd,
        byte_mode: instr.byte_mode,
        lane:      instr.rd_lane,
        wdata:     alu_value  // Byte mode uses only the low byte
    };

    // Result strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= instr_valid;
        end
    end

    // Result payload, r0 destination still reports the value
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            res <= '{rd: instr.rd, value: alu_value, flags: alu_flags};
        end
    end

endmodule

`default_nettype wire

//--- hdl/rop_top.sv
`default_nettype none

module rop_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 instr_valid,  // Plain strobe, no stall
    input  rop_pkg::rop_instr_t  instr,
    output logic                 res_valid,
    output rop_pkg::rop_result_t res
);

    import rop_pkg::*;

    // Register file ports
    rop_rd_req_t rd_a;
    rop_rd_req_t rd_b;
    rop_word_t   a_rdata;
    rop_word_t   b_rdata;
    rop_wr_req_t wr;

    // ALU ports
    rop_op_e     alu_op;
    logic        alu_byte;
    rop_word_t   alu_opa;
    rop_word_t   alu_opb;
    rop_byte_t   alu_imm;
    rop_word_t   alu_value;
    rop_flags_t  alu_flags;

    rop_ctrl i_ctrl (
        .clk,
        .arst_n,
        .instr_valid,
        .instr,
        .rd_a,
        .rd_b,
        .a_rdata,
        .b_rdata,
        .alu_op,
        .alu_byte,
        .alu_opa,
        .alu_opb,
        .alu_imm,
        .alu_value,
        .alu_flags,
        .wr,
        .res_valid,
        .res
    );

    rop_ba_regfile i_regfile (
        .clk,
        .arst_n,
        .rd_a,
        .rd_b,
        .a_rdata,
        .b_rdata,
        .wr
    );

    // Pure combinational datapath between read and write
    rop_alu i_alu (
        .op        (alu_op),
        .byte_mode (alu_byte),
        .opa       (alu_opa),
        .opb       (alu_opb),
        .imm       (alu_imm),
        .value     (alu_value),
        .flags     (alu_flags)
    );

endmodule

`default_nettype wire

//--- verif/tb_rop_top.sv
`default_nettype none

module tb_rop_top;

    import rop_pkg::*;

    logic        clk;
    logic        arst_n;
    logic        instr_valid;  // One instruction per high cycle
    rop_instr_t  instr;
    logic        res_valid;
    rop_result_t res;

    // Vectors loaded from the tests file, one entry per line
    int          gap_q[$];        // Idle cycles before the instruction
    rop_instr_t  instr_q[$];
    rop_word_t   exp_value_q[$];
    rop_flags_t  exp_flags_q[$];

    int cycle_cnt;    // Clock cycles since time zero
    int cycle_limit;  // Zero until the tests are loaded
    int cur_test;     // Index shown in error lines

    rop_top i_dut (
        .clk,
        .arst_n,
        .instr_valid,
        .instr,
        .res_valid,
        .res
    );

    always #5 clk = ~clk;  // Period 10

    // Print the reason, then the fail line, then stop
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input rop_word_t got, input rop_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s in test %0d got 0x%08h expected 0x%08h",
                                name, cur_test, got, exp));
        end
    endtask

    task automatic check_flags(input string name, input rop_flags_t got, input rop_flags_t exp);
        if (got !== exp) begin
            // Flags print as {zero, carry}
            abort_run($sformatf("CHECK FAILED: %s in test %0d got 0x%01h expected 0x%01h",
                                name, cur_test, got, exp));
        end
    endtask

    task automatic check_rd(input string name, input rop_reg_addr_t got,
                            input rop_reg_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s in test %0d got 0x%02h expected 0x%02h",
                                name, cur_test, got, exp));
        end
    endtask

    // Reads every line, columns as in the loop below
    task automatic load_tests();
        int         fd;
        int         n;
        int         fld [9];   // gap op rd rs1 rs2 byte_mode rd_lane rs1_lane rs2_lane
        logic [7:0] imm;
        rop_word_t  value;
        logic [1:0] flags;
        rop_instr_t ins;
        fd = $fopen("verif/rop_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open verif/rop_tests.txt for reading");
        end
        while (1) begin
            n = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                        fld[8], imm, value, flags);
            if (n == -1) begin
                break;  // End of file
            end
            if (n != 12) begin
                abort_run($sformatf("Tests file line %0d is malformed", gap_q.size() + 1));
            end
            ins.op        = rop_op_e'(fld[1]);
            ins.rd        = rop_reg_addr_t'(fld[2]);
            ins.rs1       = rop_reg_addr_t'(fld[3]);
            ins.rs2       = rop_reg_addr_t'(fld[4]);
            ins.byte_mode = fld[5][0];
            ins.rd_lane   = rop_lane_t'(fld[6]);
            ins.rs1_lane  = rop_lane_t'(fld[7]);
            ins.rs2_lane  = rop_lane_t'(fld[8]);
            ins.imm       = imm;
            gap_q.push_back(fld[0]);
            instr_q.push_back(ins);
            exp_value_q.push_back(value);
            exp_flags_q.push_back(rop_flags_t'(flags));
        end
        $fclose(fd);
        if (gap_q.size() == 0) begin
            abort_run("The tests file holds no tests");
        end
    endtask

    // Result strobe is due exactly one cycle after its instruction
    task automatic check_result(input int idx);
        if (idx < 0) begin
            if (res_valid !== 1'b0) begin
                abort_run("Result strobe seen with no instruction in flight");
            end
        end else begin
            cur_test = idx;
            if (res_valid !== 1'b1) begin
                abort_run($sformatf("No result strobe one cycle after test %0d", idx));
            end
            check_rd("res.rd", res.rd, instr_q[idx].rd);  // Destination of the issued op
            check_value("res.value", res.value, exp_value_q[idx]);
            check_flags("res.flags", res.flags, exp_flags_q[idx]);
        end
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, run did not finish", cycle_limit));
        end
    end

    initial begin
        int idx;       // Next test to issue
        int gap_left;  // Idle cycles still owed before test idx
        int prev;      // Test issued in the previous cycle, or -1
        int cur;
        int max_gap;
        clk         = 1'b0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        cur_test    = -1;
        load_tests();
        max_gap = 0;
        foreach (gap_q[i]) begin
            if (gap_q[i] > max_gap) begin
                max_gap = gap_q[i];
            end
        end
        cycle_limit = gap_q.size() * (max_gap + 2) + 20;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;  // Release after 2 cycles
        idx      = 0;
        prev     = -1;
        gap_left = gap_q[0];
        while (idx < gap_q.size() || prev >= 0) begin
            @(posedge clk);
            cur = -1;
            if (idx < gap_q.size() && gap_left == 0) begin
                instr_valid <= 1'b1;
                instr       <= instr_q[idx];
                cur = idx;
                idx = idx + 1;
                if (idx < gap_q.size()) begin
                    gap_left = gap_q[idx];
                end
            end else begin
                instr_valid <= 1'b0;  // Idle cycle
                if (idx < gap_q.size()) begin
                    gap_left = gap_left - 1;
                end
            end
            @(negedge clk);  // Outputs settled mid-cycle
            check_result(prev);
            prev = cur;
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/rop_tests.txt
1 0 1 2 3 0 0 0 0 00 00000000 2
0 5 0 0 0 0 0 0 0 5a 0000005a 0
0 3 4 0 0 0 0 0 0 00 00000000 2
2 5 1 0 0 0 0 0 0 ff 000000ff 0
0 5 2 0 0 0 0 0 0 01 00000001 0
0 0 3 1 2 0 0 0 0 00 00000100 0
1 1 4 2 1 0 0 0 0 00 ffffff02 1
0 0 5 4 3 0 0 0 0 00 00000002 1
0 2 6 4 1 0 0 0 0 00 00000002 0
0 3 7 1 3 0 0 0 0 00 000001ff 0
0 4 8 4 4 0 0 0 0 00 00000000 2
3 1 9 3 3 0 0 0 0 00 00000000 2
0 4 10 4 7 0 0 0 0 00 fffffefd 0
1 5 12 0 0 1 0 0 0 11 00000011 0
0 5 12 0 0 1 1 0 0 22 00000022 0
0 5 12 0 0 1 2 0 0 33 00000033 0
0 5 12 0 0 1 3 0 0 44 00000044 0
0 3 13 12 0 0 0 0 0 00 44332211 0
0 5 12 0 0 1 2 0 0 00 00000000 2
0 3 14 12 0 0 0 0 0 00 44002211 0
2 0 15 12 13 1 1 3 2 00 00000077 0
0 0 15 4 12 1 2 3 3 00 00000043 1
0 3 16 15 0 0 0 0 0 00 00437700 0
1 1 15 13 13 1 3 0 1 00 000000ef 1
0 0 15 4 2 1 0 3 0 00 00000000 3
0 3 17 15 0 0 0 0 0 00 ef437700 0
2 5 20 0 0 0 0 0 0 7f 0000007f 0
0 0 20 20 20 0 0 0 0 00 000000fe 0
0 0 20 20 20 0 0 0 0 00 000001fc 0
0 1 21 20 2 0 0 0 0 00 000001fb 0
0 4 21 21 21 0 0 0 0 00 00000000 2
0 3 22 21 20 0 0 0 0 00 000001fc 0
0 3 23 0 0 0 0 0 0 00 00000000 2

//--- tb.f
hdl/rop_pkg.sv
hdl/rop_ba_regfile.sv
hdl/rop_alu.sv
hdl/rop_ctrl.sv
hdl/rop_top.sv
verif/tb_rop_top.sv

//--- Bender.yml
package:
  name: rop

dependencies: {}

sources:
  # RTL in compile order
  - hdl/rop_pkg.sv
  - hdl/rop_ba_regfile.sv
  - hdl/rop_alu.sv
  - hdl/rop_ctrl.sv
  - hdl/rop_top.sv

  # Testbench
  - target: test
    files:
      - verif/tb_rop_top.sv
